// ==== Bender.yml ====
package:
  name: gcn_agg

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gcn_pkg.sv
      - hdl/gcn_ctrl.sv
      - hdl/adj_builder.sv
      - hdl/feat_aggregator.sv
      - hdl/gcn_agg_top.sv

  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/gcn_tb.sv

// ==== build.f ====
+incdir+hdl
+incdir+dv
hdl/gcn_pkg.sv
hdl/gcn_ctrl.sv
hdl/adj_builder.sv
hdl/feat_aggregator.sv
hdl/gcn_agg_top.sv
dv/gcn_tb.sv

// ==== dv/gcn_tb_table.svh ====
`ifndef GCN_TB_TABLE_SVH
`define GCN_TB_TABLE_SVH

//////////////////////////////////////////////////////////////////////
// job table, one row per job
//////////////////////////////////////////////////////////////////////

localparam int NUM_TABLE_JOBS = 6;

string tbl_name [NUM_TABLE_JOBS] = '{
    "ring", "star", "path", "decode", "max_sum", "no_edges"
};

// edge slot e joins ids tbl_src[j][e] and tbl_dst[j][e], one-based
int tbl_src [NUM_TABLE_JOBS][`GCN_NUM_EDGES] = '{
    '{1, 2, 3, 4, 5, 6},
    '{1, 1, 1, 1, 1, 0},
    '{1, 2, 3, 4, 5, 0},
    '{0, 7, 1, 2, 1, 3},    // two bad ids, a duplicate, a reversed duplicate, a self loop
    '{1, 1, 1, 1, 1, 1},
    '{0, 7, 0, 6, 7, 0}
};

int tbl_dst [NUM_TABLE_JOBS][`GCN_NUM_EDGES] = '{
    '{2, 3, 4, 5, 6, 1},
    '{2, 3, 4, 5, 6, 0},
    '{2, 3, 4, 5, 6, 0},
    '{3, 2, 2, 1, 2, 3},
    '{1, 2, 3, 4, 5, 6},    // star plus a self loop on node 0
    '{5, 1, 0, 0, 7, 7}
};

// [job][column][node]
int tbl_feat [NUM_TABLE_JOBS][`GCN_NUM_COLS][`GCN_NUM_NODES] = '{
    '{'{1, 2, 3, 4, 5, 6},        '{10, 11, 12, 13, 14, 15}},
    '{'{7, 1, 2, 3, 4, 5},        '{31, 30, 29, 28, 27, 26}},
    '{'{3, 9, 27, 1, 17, 22},     '{0, 5, 10, 15, 20, 25}},
    '{'{4, 8, 16, 2, 30, 19},     '{12, 6, 3, 24, 21, 9}},
    '{'{31, 31, 31, 31, 31, 31},  '{31, 31, 31, 31, 31, 31}},
    '{'{11, 22, 13, 24, 15, 26},  '{31, 1, 31, 1, 31, 1}}
};

// out_ready per cycle, bit k used on cycle k mod 8
logic [7:0] tbl_stall [NUM_TABLE_JOBS] = '{
    8'hFF, 8'b1010_1010, 8'b1000_0001, 8'b0011_0011, 8'b0100_0000, 8'hFF
};

`endif

// ==== dv/gcn_tb.sv ====
`timescale 1ns/1ps
`include "gcn_macros.svh"

module gcn_tb import gcn_pkg::*; ();

    `include "gcn_tb_table.svh"

    localparam int NUM_RAND_JOBS = 4;
    localparam int NUM_JOBS      = NUM_TABLE_JOBS + NUM_RAND_JOBS;
    localparam int MAX_STALL     = 7;    // longest zero run of an 8 bit pattern with one bit set
    localparam int JOB_CYCLES    = `GCN_NUM_EDGES + `GCN_NUM_NODES * (2 + MAX_STALL) + 4;
    localparam int WATCHDOG_NS   = NUM_JOBS * JOB_CYCLES * 8 + 16 * 8;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    logic out_valid;
    logic out_ready;
    node_id_t [`GCN_NUM_EDGES-1:0]                 edge_src;
    node_id_t [`GCN_NUM_EDGES-1:0]                 edge_dst;
    feat_t [`GCN_NUM_COLS-1:0][`GCN_NUM_NODES-1:0] features;
    node_idx_t                                     out_node;
    sum_t [`GCN_NUM_COLS-1:0]                      out_sum;

    string      job_name  [NUM_JOBS];
    int         job_src   [NUM_JOBS][`GCN_NUM_EDGES];
    int         job_dst   [NUM_JOBS][`GCN_NUM_EDGES];
    int         job_feat  [NUM_JOBS][`GCN_NUM_COLS][`GCN_NUM_NODES];
    logic [7:0] job_stall [NUM_JOBS];

    int         exp_sum [`GCN_NUM_NODES][`GCN_NUM_COLS];
    logic [7:0] stall_pat;
    logic [2:0] stall_pos;
    int         n_pass;
    int         n_fail;

    gcn_agg_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .edge_src  (edge_src),
        .edge_dst  (edge_dst),
        .features  (features),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_node  (out_node),
        .out_sum   (out_sum)
    );

    always #4 clk = ~clk;

    // consumer side, walks the stall pattern one bit per cycle
    always @(posedge clk) begin
        #1;
        out_ready = stall_pat[stall_pos];
        stall_pos = stall_pos + 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // job setup and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic fill_jobs();
        for (int j = 0; j < NUM_JOBS; j++) begin
            if (j < NUM_TABLE_JOBS) begin
                job_name[j]  = tbl_name[j];
                job_stall[j] = tbl_stall[j];
            end else begin
                job_name[j]  = $sformatf("random_%0d", j - NUM_TABLE_JOBS);
                job_stall[j] = 8'($urandom_range(255, 0)) | 8'h01;
            end
            for (int e = 0; e < `GCN_NUM_EDGES; e++) begin
                job_src[j][e] = (j < NUM_TABLE_JOBS) ? tbl_src[j][e] : $urandom_range(7, 0);
                job_dst[j][e] = (j < NUM_TABLE_JOBS) ? tbl_dst[j][e] : $urandom_range(7, 0);
            end
            for (int c = 0; c < `GCN_NUM_COLS; c++) begin
                for (int n = 0; n < `GCN_NUM_NODES; n++) begin
                    job_feat[j][c][n] = (j < NUM_TABLE_JOBS) ? tbl_feat[j][c][n]
                                                             : $urandom_range(31, 0);
                end
            end
        end
    endtask

    // neighbour sums straight from the edge rules
    function automatic void build_expected(input int j);
        bit adj [`GCN_NUM_NODES][`GCN_NUM_NODES];
        int a;
        int b;
        for (int n = 0; n < `GCN_NUM_NODES; n++) begin
            for (int m = 0; m < `GCN_NUM_NODES; m++)
                adj[n][m] = 1'b0;
        end
        for (int e = 0; e < `GCN_NUM_EDGES; e++) begin
            a = job_src[j][e];
            b = job_dst[j][e];
            if (a >= 1 && a <= `GCN_NUM_NODES && b >= 1 && b <= `GCN_NUM_NODES) begin
                adj[a-1][b-1] = 1'b1;
                adj[b-1][a-1] = 1'b1;
            end
        end
        for (int n = 0; n < `GCN_NUM_NODES; n++) begin
            for (int c = 0; c < `GCN_NUM_COLS; c++) begin
                exp_sum[n][c] = 0;
                for (int m = 0; m < `GCN_NUM_NODES; m++) begin
                    if (adj[n][m])
                        exp_sum[n][c] += job_feat[j][c][m];
                end
            end
        end
    endfunction

    task automatic drive_job(input int j);
        for (int e = 0; e < `GCN_NUM_EDGES; e++) begin
            edge_src[e] = node_id_t'(job_src[j][e]);
            edge_dst[e] = node_id_t'(job_dst[j][e]);
        end
        for (int c = 0; c < `GCN_NUM_COLS; c++) begin
            for (int n = 0; n < `GCN_NUM_NODES; n++)
                features[c][n] = feat_t'(job_feat[j][c][n]);
        end
        in_valid = 1'b1;
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            n_pass++;
            $display("test %-10s ok", name);
        end else begin
            n_fail++;
            $display("test %-10s FAILED with %0d errors", name, errs);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one job, from acceptance to the last result
    //////////////////////////////////////////////////////////////////////

    task automatic run_job(input int j);
        int                       errs;
        int                       got;
        int                       wait_cycles;
        bit                       seen_valid;
        bit                       holding;
        node_idx_t                held_node;
        sum_t [`GCN_NUM_COLS-1:0] held_sum;
        errs        = 0;
        got         = 0;
        wait_cycles = 0;
        seen_valid  = 1'b0;
        holding     = 1'b0;
        build_expected(j);
        @(posedge clk);
        #1;
        drive_job(j);
        @(negedge clk);
        stall_pat = job_stall[j];
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);     // job taken on this edge
        #1;
        if (j + 1 < NUM_JOBS)
            drive_job(j + 1);   // next job waits with in_valid held high
        else
            in_valid = 1'b0;

        while (got < `GCN_NUM_NODES) begin
            @(negedge clk);
            assert (!in_ready) else begin
                $display("%s: engine offered to take a new job before its last result", job_name[j]);
                errs++;
            end
            if (!out_valid) begin
                if (!seen_valid)
                    wait_cycles++;
                assert (!holding) else begin
                    $display("%s: out_valid dropped while the result was stalled", job_name[j]);
                    errs++;
                end
                holding = 1'b0;
            end else begin
                if (!seen_valid) begin
                    assert (wait_cycles == `GCN_NUM_EDGES + 1) else begin
                        $display("[ERROR] %s first result latency: expected %0d, actual %0d",
                                 job_name[j], `GCN_NUM_EDGES + 1, wait_cycles);
                        errs++;
                    end
                end
                seen_valid = 1'b1;
                if (holding) begin
                    assert (out_node == held_node && out_sum == held_sum) else begin
                        $display("[ERROR] %s result changed under stall: expected %0d/%h, actual %0d/%h",
                                 job_name[j], held_node, held_sum, out_node, out_sum);
                        errs++;
                    end
                end
                if (out_ready) begin
                    assert (out_node == node_idx_t'(got)) else begin
                        $display("[ERROR] %s node order: expected %0d, actual %0d",
                                 job_name[j], got, out_node);
                        errs++;
                    end
                    for (int c = 0; c < `GCN_NUM_COLS; c++) begin
                        assert (int'(out_sum[c]) == exp_sum[got][c]) else begin
                            $display("[ERROR] %s node %0d col %0d: expected %0d, actual %0d",
                                     job_name[j], got, c, exp_sum[got][c], out_sum[c]);
                            errs++;
                        end
                    end
                    got++;
                    holding = 1'b0;
                end else begin
                    holding   = 1'b1;
                    held_node = out_node;
                    held_sum  = out_sum;
                end
            end
        end
        report_test(job_name[j], errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        int errs;
        void'($urandom(45));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        edge_src  = '0;
        edge_dst  = '0;
        features  = '0;
        stall_pat = 8'hFF;
        stall_pos = '0;
        n_pass    = 0;
        n_fail    = 0;
        errs      = 0;
        fill_jobs();

        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        assert (in_ready && !out_valid) else begin
            $display("after reset: in_ready is %b and out_valid is %b", in_ready, out_valid);
            errs++;
        end
        report_test("after_reset", errs);

        for (int j = 0; j < NUM_JOBS; j++)
            run_job(j);

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the engine did not finish all jobs in the allowed time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== hdl/adj_builder.sv ====
`timescale 1ns/1ps
`include "gcn_macros.svh"

module adj_builder import gcn_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic                               capture,
    input  logic                               build_en,
    input  node_id_t [`GCN_NUM_EDGES-1:0]      edge_src,
    input  node_id_t [`GCN_NUM_EDGES-1:0]      edge_dst,

    input  node_idx_t                          edge_idx,   // slot decoded in BUILD
    input  node_idx_t                          node_idx,   // row read out
    output adj_row_t                           adj_row
);

    node_id_t [`GCN_NUM_EDGES-1:0] src_r;
    node_id_t [`GCN_NUM_EDGES-1:0] dst_r;

    adj_row_t [`GCN_NUM_NODES-1:0] adj_mat;
    adj_row_t [`GCN_NUM_NODES-1:0] adj_next;

    adj_row_t mask_a;
    adj_row_t mask_b;
    logic     pair_ok;

    // one-hot of a one-based id, ids 0 and above the node count give zero
    function automatic adj_row_t id_to_mask(input node_id_t id);
        adj_row_t mask;
        mask = '0;
        for (int n = 0; n < `GCN_NUM_NODES; n++) begin
            if (id == node_id_t'(n + 1))
                mask[n] = 1'b1;
        end
        return mask;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // edge decode
    //////////////////////////////////////////////////////////////////////

    assign mask_a  = id_to_mask(src_r[edge_idx]);
    assign mask_b  = id_to_mask(dst_r[edge_idx]);
    assign pair_ok = (|mask_a) && (|mask_b);   // both ends must be real nodes

    // each endpoint picks up the other one as a neighbour
    // a self loop lands the same bit twice, which ORs to one
    always_comb begin
        for (int r = 0; r < `GCN_NUM_NODES; r++) begin
            adj_next[r] = adj_mat[r];
            if (pair_ok) begin
                if (mask_a[r])
                    adj_next[r] = adj_next[r] | mask_b;
                if (mask_b[r])
                    adj_next[r] = adj_next[r] | mask_a;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // edge list and matrix storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_r   <= '0;
            dst_r   <= '0;
            adj_mat <= '0;
        end else if (capture) begin
            src_r   <= edge_src;
            dst_r   <= edge_dst;
            adj_mat <= '0;          // previous job's edges go away here
        end else if (build_en) begin
            adj_mat <= adj_next;
        end
    end

    assign adj_row = adj_mat[node_idx];

endmodule

// ==== hdl/feat_aggregator.sv ====
`timescale 1ns/1ps
`include "gcn_macros.svh"

module feat_aggregator import gcn_pkg::*; (
    input  logic                                          clk,
    input  logic                                          rst_n,

    input  logic                                          capture,
    input  logic                                          sum_load,

    // [column][node]
    input  feat_t [`GCN_NUM_COLS-1:0][`GCN_NUM_NODES-1:0] features,

    input  adj_row_t                                      adj_row,
    input  node_idx_t                                     node_idx,

    output node_idx_t                                     out_node,
    output sum_t [`GCN_NUM_COLS-1:0]                      out_sum
);

    // tree leaves padded up to a power of two
    localparam int TREE_LVLS = $clog2(`GCN_NUM_NODES);
    localparam int LEAVES    = 1 << TREE_LVLS;
    localparam int TREE_SIZE = 2 * LEAVES - 1;

    feat_t [`GCN_NUM_COLS-1:0][`GCN_NUM_NODES-1:0] feat_r;

    sum_t tree [`GCN_NUM_COLS][TREE_SIZE];   // heap order, root at 0
    sum_t [`GCN_NUM_COLS-1:0] col_sum;

    //////////////////////////////////////////////////////////////////////
    // feature register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feat_r <= '0;
        end else if (capture) begin
            feat_r <= features;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // masked adder tree, one per column
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < `GCN_NUM_COLS; c++) begin
            // padding leaves stay zero
            for (int l = 0; l < LEAVES; l++) begin
                tree[c][LEAVES-1+l] = '0;
            end

            // only neighbours of the selected node feed the tree
            for (int l = 0; l < `GCN_NUM_NODES; l++) begin
                if (adj_row[l])
                    tree[c][LEAVES-1+l] = sum_t'(feat_r[c][l]);
            end

            // inner nodes, walked from the bottom up
            for (int i = LEAVES - 2; i >= 0; i--) begin
                tree[c][i] = tree[c][2*i+1] + tree[c][2*i+2];
            end

            col_sum[c] = tree[c][0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    // loaded once per node, then held while the consumer stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_sum  <= '0;
            out_node <= '0;
        end else if (sum_load) begin
            out_sum  <= col_sum;
            out_node <= node_idx;
        end
    end

endmodule

// ==== hdl/gcn_agg_top.sv ====
`timescale 1ns/1ps
`include "gcn_macros.svh"

module gcn_agg_top import gcn_pkg::*; (
    input  logic                                          clk,
    input  logic                                          rst_n,

    // job input
    input  logic                                          in_valid,
    output logic                                          in_ready,
    input  node_id_t [`GCN_NUM_EDGES-1:0]                 edge_src,
    input  node_id_t [`GCN_NUM_EDGES-1:0]                 edge_dst,
    input  feat_t [`GCN_NUM_COLS-1:0][`GCN_NUM_NODES-1:0] features,

    // result stream, one node per transfer
    output logic                                          out_valid,
    input  logic                                          out_ready,
    output node_idx_t                                     out_node,
    output sum_t [`GCN_NUM_COLS-1:0]                      out_sum
);

    logic      capture;
    logic      build_en;
    logic      sum_load;
    node_idx_t edge_idx;
    node_idx_t node_idx;
    adj_row_t  adj_row;     // neighbours of node_idx

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    gcn_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .capture   (capture),
        .build_en  (build_en),
        .sum_load  (sum_load),
        .edge_idx  (edge_idx),
        .node_idx  (node_idx)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    adj_builder u_adj (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .build_en (build_en),
        .edge_src (edge_src),
        .edge_dst (edge_dst),
        .edge_idx (edge_idx),
        .node_idx (node_idx),
        .adj_row  (adj_row)
    );

    feat_aggregator u_agg (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .sum_load (sum_load),
        .features (features),
        .adj_row  (adj_row),
        .node_idx (node_idx),
        .out_node (out_node),
        .out_sum  (out_sum)
    );

endmodule

// ==== hdl/gcn_ctrl.sv ====
`timescale 1ns/1ps
`include "gcn_macros.svh"

module gcn_ctrl import gcn_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // job input handshake
    input  logic      in_valid,
    output logic      in_ready,

    // result stream handshake
    output logic      out_valid,
    input  logic      out_ready,

    // controls to the data blocks
    output logic      capture,
    output logic      build_en,
    output logic      sum_load,
    output node_idx_t edge_idx,
    output node_idx_t node_idx
);

    gcn_state_e state;

    logic last_edge;
    logic last_node;
    logic transfer;

    //////////////////////////////////////////////////////////////////////
    // decoded outputs
    //////////////////////////////////////////////////////////////////////

    assign in_ready  = (state == IDLE);
    assign build_en  = (state == BUILD);
    assign sum_load  = (state == AGGREGATE);
    assign out_valid = (state == EMIT);

    assign capture  = in_valid && in_ready;    // one cycle, IDLE only
    assign transfer = out_valid && out_ready;

    assign last_edge = (edge_idx == node_idx_t'(`GCN_NUM_EDGES - 1));
    assign last_node = (node_idx == node_idx_t'(`GCN_NUM_NODES - 1));

    //////////////////////////////////////////////////////////////////////
    // state register and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            edge_idx <= '0;
            node_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (capture)
                        state <= BUILD;
                end

                BUILD: begin
                    if (last_edge) begin
                        edge_idx <= '0;      // ready for the next job
                        state    <= AGGREGATE;
                    end else begin
                        edge_idx <= edge_idx + 1'b1;
                    end
                end

                // sums of node_idx get registered this cycle
                AGGREGATE: begin
                    state <= EMIT;
                end

                // hold here for as long as the consumer stalls
                EMIT: begin
                    if (transfer) begin
                        if (last_node) begin
                            node_idx <= '0;
                            state    <= IDLE;
                        end else begin
                            node_idx <= node_idx + 1'b1;
                            state    <= AGGREGATE;
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/gcn_macros.svh ====
`ifndef GCN_MACROS_SVH
`define GCN_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// graph dimensions
//////////////////////////////////////////////////////////////////////

// number of graph nodes, also the length of one feature column
`define GCN_NUM_NODES 6

// edge slots carried by one job
`define GCN_NUM_EDGES 6

// feature columns per node
`define GCN_NUM_COLS 2

//////////////////////////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////////////////////////

`define GCN_FEAT_W 5      // one unsigned feature element

// one-based node id, 0 marks an empty edge slot
`define GCN_NODE_ID_W 3

// room for GCN_NUM_NODES * (2**GCN_FEAT_W - 1) = 186
`define GCN_SUM_W 8

`endif

// ==== hdl/gcn_pkg.sv ====
`include "gcn_macros.svh"

package gcn_pkg;

    //////////////////////////////////////////////////////////////////////
    // job control
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE      = 2'd0,   // waiting for a job
        BUILD     = 2'd1,   // one edge per cycle into the matrix
        AGGREGATE = 2'd2,   // sums of one node loaded
        EMIT      = 2'd3    // result offered downstream
    } gcn_state_e;

    //////////////////////////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////////////////////////

    // ids as they arrive in the edge list, node n is id n+1
    typedef logic [`GCN_NODE_ID_W-1:0] node_id_t;

    // zero-based index, shared by edge slots and nodes
    typedef logic [2:0] node_idx_t;

    typedef logic [`GCN_FEAT_W-1:0] feat_t;
    typedef logic [`GCN_SUM_W-1:0]  sum_t;

    // bit m set means node m is a neighbour
    typedef logic [`GCN_NUM_NODES-1:0] adj_row_t;

endpackage
